// ==== verilog/data_mem_macros.svh ====
`ifndef DATA_MEM_MACROS_SVH
`define DATA_MEM_MACROS_SVH

// depth of the data memory in words
`define DATA_MEM_WORDS 1024

// byte lanes per word
// stays at 4 since halfword and word accesses assume a 32-bit word
`define DATA_MEM_BYTES 4

`endif

// ==== verilog/data_mem_pkg.sv ====
`include "data_mem_macros.svh"

package data_mem_pkg;

// payload of a single byte lane
typedef logic [7:0] mem_byte_t;

// full data word made of byte lanes
// lane 0 holds the lowest byte address
typedef mem_byte_t [`DATA_MEM_BYTES-1:0] mem_word_t;

// width of a load or store
typedef enum logic [1:0] {
	SIZE_BYTE = 2'b00,
	SIZE_HALF = 2'b01,
	SIZE_WORD = 2'b10 // 2'b11 is reserved
} access_size_e;

endpackage

// ==== verilog/single_port_ram.sv ====
module single_port_ram #(
	// payload width when dtype is left as plain logic
	parameter int unsigned DATA_WIDTH = 32,
	// depth in dtype entries
	parameter int unsigned SIZE       = 1024,
	parameter type dtype              = logic [DATA_WIDTH-1:0]
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     we,
	input  logic [$clog2(SIZE)-1:0]  addr,
	input  dtype                     din,
	output dtype                     dout
);

// storage array, contents undefined until written
dtype mem [SIZE];

always_ff @(posedge clk) begin
	if (we) begin
		mem[addr] <= din;
	end
end

// output register with one cycle read latency
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		dout <= '0;
	end else if (we) begin
		dout <= din; // write-first
	end else begin
		dout <= mem[addr];
	end
end

endmodule

// ==== verilog/single_port_byte_ram.sv ====
module single_port_byte_ram #(
	parameter int unsigned BYTES_WIDTH = 4,
	// depth in words
	parameter int unsigned SIZE        = 1024
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     we,
	input  logic [BYTES_WIDTH-1:0]   byteenable,
	input  logic [$clog2(SIZE)-1:0]  addr,
	input  data_mem_pkg::mem_word_t  din,
	output data_mem_pkg::mem_word_t  dout
);

import data_mem_pkg::*;

// per-lane split of the write word and merge of the read word
mem_byte_t lane_din  [BYTES_WIDTH];
mem_byte_t lane_dout [BYTES_WIDTH];

for (genvar i = 0; i < BYTES_WIDTH; i++) begin : gen_lane
	assign lane_din[i] = din[i];
	assign dout[i]     = lane_dout[i];

	// one byte-wide ram per lane
	single_port_ram #(
		.SIZE  ( SIZE       ),
		.dtype ( mem_byte_t )
	) u_lane_ram (
		.clk   ( clk                ),
		.rst_n ( rst_n              ),
		.we    ( we & byteenable[i] ), // lane only written when enabled
		.addr  ( addr               ),
		.din   ( lane_din[i]        ),
		.dout  ( lane_dout[i]       )
	);
end

endmodule

// ==== verilog/lsu_align.sv ====
`include "data_mem_macros.svh"

module lsu_align (
	input  logic                                                  clk,
	input  logic                                                  rst_n,
	input  logic                                                  req,
	input  logic                                                  we,
	input  data_mem_pkg::access_size_e                            size,
	input  logic                                                  unsigned_load,
	input  logic [$clog2(`DATA_MEM_WORDS * `DATA_MEM_BYTES)-1:0]  addr,
	input  data_mem_pkg::mem_word_t                               wdata,
	output logic                                                  ram_we,
	output logic [`DATA_MEM_BYTES-1:0]                            ram_be,
	output logic [$clog2(`DATA_MEM_WORDS)-1:0]                    ram_addr,
	output data_mem_pkg::mem_word_t                               ram_din,
	input  data_mem_pkg::mem_word_t                               ram_dout,
	output data_mem_pkg::mem_word_t                               rdata,
	output logic                                                  rvalid,
	output logic                                                  misaligned
);

import data_mem_pkg::*;

localparam int unsigned OFF_W  = $clog2(`DATA_MEM_BYTES);
localparam int unsigned ADDR_W = $clog2(`DATA_MEM_WORDS * `DATA_MEM_BYTES);

logic [OFF_W-1:0]           offset;
logic                       aligned;
logic [`DATA_MEM_BYTES-1:0] be_base;

// request fields held for the returning read data
logic [OFF_W-1:0]           offset_q;
access_size_e               size_q;
logic                       unsigned_q;

mem_byte_t                  lane_byte;
logic [15:0]                lane_half;
logic [31:0]                load_ext;

assign offset   = addr[OFF_W-1:0];
assign ram_addr = addr[ADDR_W-1:OFF_W]; // word address

// natural alignment check
always_comb begin
	case (size)
		SIZE_BYTE: aligned = 1'b1;
		SIZE_HALF: aligned = ~offset[0];
		SIZE_WORD: aligned = (offset == '0);
		default:   aligned = 1'b0; // reserved size rejected like a misaligned access
	endcase
end

// store steering
// replicating the low bytes puts them on every lane they can land on
always_comb begin
	case (size)
		SIZE_BYTE: begin
			be_base = `DATA_MEM_BYTES'(1);
			ram_din = {`DATA_MEM_BYTES{wdata[0]}};
		end
		SIZE_HALF: begin
			be_base = `DATA_MEM_BYTES'(3);
			ram_din = {(`DATA_MEM_BYTES / 2){wdata[1], wdata[0]}};
		end
		default: begin
			be_base = '1;
			ram_din = wdata;
		end
	endcase
end

assign ram_be = be_base << offset;
assign ram_we = req & we & aligned; // misaligned stores never reach the ram

// response strobes, one cycle after req
always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		rvalid     <= 1'b0;
		misaligned <= 1'b0;
	end else begin
		rvalid     <= req & ~we & aligned;
		misaligned <= req & ~aligned;
	end
end

always_ff @(posedge clk) begin
	if (req) begin
		offset_q   <= offset;
		size_q     <= size;
		unsigned_q <= unsigned_load;
	end
end

// lane select on the returned word
always_comb begin
	lane_byte = ram_dout[offset_q];
	lane_half = {ram_dout[{offset_q[1], 1'b1}], ram_dout[{offset_q[1], 1'b0}]};
	case (size_q)
		SIZE_BYTE: load_ext = {{24{~unsigned_q & lane_byte[7]}}, lane_byte};
		SIZE_HALF: load_ext = {{16{~unsigned_q & lane_half[15]}}, lane_half};
		default:   load_ext = ram_dout;
	endcase
end

// rdata is zero outside the rvalid cycle
assign rdata = rvalid ? load_ext : '0;

endmodule

// ==== verilog/data_mem_top.sv ====
`include "data_mem_macros.svh"

module data_mem_top (
	input  logic                                                  clk,
	input  logic                                                  rst_n,
	input  logic                                                  req,
	input  logic                                                  we,
	input  data_mem_pkg::access_size_e                            size,
	input  logic                                                  unsigned_load,
	input  logic [$clog2(`DATA_MEM_WORDS * `DATA_MEM_BYTES)-1:0]  addr,
	input  data_mem_pkg::mem_word_t                               wdata,
	output data_mem_pkg::mem_word_t                               rdata,
	output logic                                                  rvalid,
	output logic                                                  misaligned
);

import data_mem_pkg::*;

// alignment unit to ram
logic                                ram_we;
logic [`DATA_MEM_BYTES-1:0]          ram_be;
logic [$clog2(`DATA_MEM_WORDS)-1:0]  ram_addr;
mem_word_t                           ram_din;
mem_word_t                           ram_dout;

lsu_align u_lsu_align (
	.clk           ( clk           ),
	.rst_n         ( rst_n         ),
	.req           ( req           ),
	.we            ( we            ),
	.size          ( size          ),
	.unsigned_load ( unsigned_load ),
	.addr          ( addr          ),
	.wdata         ( wdata         ),
	.ram_we        ( ram_we        ),
	.ram_be        ( ram_be        ),
	.ram_addr      ( ram_addr      ),
	.ram_din       ( ram_din       ),
	.ram_dout      ( ram_dout      ),
	.rdata         ( rdata         ),
	.rvalid        ( rvalid        ),
	.misaligned    ( misaligned    )
);

single_port_byte_ram #(
	.BYTES_WIDTH ( `DATA_MEM_BYTES ),
	.SIZE        ( `DATA_MEM_WORDS )
) u_ram (
	.clk        ( clk      ),
	.rst_n      ( rst_n    ),
	.we         ( ram_we   ),
	.byteenable ( ram_be   ),
	.addr       ( ram_addr ),
	.din        ( ram_din  ),
	.dout       ( ram_dout )
);

endmodule

// ==== bench/data_mem_asserts.sv ====
`include "data_mem_macros.svh"

module data_mem_asserts (
	input logic                                                  clk,
	input logic                                                  rst_n,
	input logic                                                  req,
	input logic                                                  we,
	input data_mem_pkg::access_size_e                            size,
	input logic [$clog2(`DATA_MEM_WORDS * `DATA_MEM_BYTES)-1:0]  addr,
	input logic                                                  rvalid,
	input logic                                                  misaligned
);

import data_mem_pkg::*;

logic aligned;
logic load_ok;
logic store_ok;

always_comb begin
	case (size)
		SIZE_BYTE: aligned = 1'b1;
		SIZE_HALF: aligned = ~addr[0];
		SIZE_WORD: aligned = (addr[1:0] == 2'b00);
		default:   aligned = 1'b0;
	endcase
end

assign load_ok  = req & ~we & aligned;
assign store_ok = req & we & aligned;

a_resp_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
	!(rvalid && misaligned))
	else $error("rvalid and misaligned high in the same cycle");

a_rvalid_source: assert property (@(posedge clk) disable iff (!rst_n)
	rvalid |-> $past(load_ok))
	else $error("rvalid without an aligned load one cycle earlier");

a_load_answered: assert property (@(posedge clk) disable iff (!rst_n)
	load_ok |=> rvalid)
	else $error("aligned load got no rvalid");

a_misaligned_source: assert property (@(posedge clk) disable iff (!rst_n)
	misaligned |-> $past(req) && !$past(aligned))
	else $error("misaligned pulse without a misaligned req");

a_misaligned_flagged: assert property (@(posedge clk) disable iff (!rst_n)
	(req && !aligned) |=> misaligned)
	else $error("misaligned req was not flagged");

a_store_quiet: assert property (@(posedge clk) disable iff (!rst_n)
	store_ok |=> !rvalid && !misaligned)
	else $error("aligned store produced a response");

endmodule

bind data_mem_top data_mem_asserts u_asserts (
	.clk        ( clk        ),
	.rst_n      ( rst_n      ),
	.req        ( req        ),
	.we         ( we         ),
	.size       ( size       ),
	.addr       ( addr       ),
	.rvalid     ( rvalid     ),
	.misaligned ( misaligned )
);

// ==== bench/data_mem_tb.sv ====
`include "data_mem_macros.svh"

module data_mem_tb;

import data_mem_pkg::*;

localparam int AW         = $clog2(`DATA_MEM_WORDS * `DATA_MEM_BYTES);
localparam int MEM_BYTES  = `DATA_MEM_WORDS * `DATA_MEM_BYTES;
localparam int CLK_PERIOD = 10;
localparam int N_ROUND    = 16;
localparam int N_MERGE    = 6;
localparam int N_B2B      = 12;

// cycles per test in run order, extension and misalignment have fixed counts
localparam int TOTAL_CYCLES = 5 + (2 * N_ROUND + 1) + (5 * N_MERGE + 1) + 29 + 13
	+ (2 * N_B2B + 1);
localparam int WATCHDOG_TIME = (TOTAL_CYCLES + 100) * CLK_PERIOD;

logic          clk;
logic          rst_n;
logic          req;
logic          we;
access_size_e  size;
logic          unsigned_load;
logic [AW-1:0] addr;
mem_word_t     wdata;
mem_word_t     rdata;
logic          rvalid;
logic          misaligned;

integer        seed;
logic [7:0]    ref_mem [MEM_BYTES]; // byte-addressed copy of the memory

data_mem_top dut (
	.clk           ( clk           ),
	.rst_n         ( rst_n         ),
	.req           ( req           ),
	.we            ( we            ),
	.size          ( size          ),
	.unsigned_load ( unsigned_load ),
	.addr          ( addr          ),
	.wdata         ( wdata         ),
	.rdata         ( rdata         ),
	.rvalid        ( rvalid        ),
	.misaligned    ( misaligned    )
);

always #(CLK_PERIOD / 2) clk = ~clk;

task automatic report_failure();
	$display("TEST RESULT: FAIL");
	$fatal(1, "stopping at the first error");
endtask

function automatic logic is_aligned(access_size_e sz, logic [AW-1:0] a);
	if (sz == SIZE_HALF)
		return ~a[0];
	if (sz == SIZE_WORD)
		return (a[1:0] == 2'b00);
	return 1'b1; // bytes never misalign
endfunction

function automatic void apply_store(access_size_e sz, logic [AW-1:0] a, logic [31:0] d);
	int n;
	n = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
	for (int i = 0; i < n; i++) begin
		ref_mem[int'(a) + i] = d[8*i +: 8];
	end
endfunction

function automatic logic [31:0] expected_load(access_size_e sz, logic uns, logic [AW-1:0] a);
	logic [7:0]  b;
	logic [15:0] h;
	b = ref_mem[int'(a)];
	h = {ref_mem[int'(a) + 1], b};
	case (sz)
		SIZE_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
		SIZE_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
		default:   return {ref_mem[int'(a) + 3], ref_mem[int'(a) + 2], h};
	endcase
endfunction

function automatic logic [AW-1:0] rand_word_addr();
	logic [31:0] r;
	r = $random(seed);
	return {r[AW-1:2], 2'b00};
endfunction

task automatic check_response(input logic exp_valid, input logic exp_mis,
		input logic [31:0] exp_data, input logic chk_data);
	assert (rvalid === exp_valid) else begin
		$display("MISMATCH at %0t: rvalid expected %0b, got %0b", $time, exp_valid, rvalid);
		report_failure();
	end
	assert (misaligned === exp_mis) else begin
		$display("MISMATCH at %0t: misaligned expected %0b, got %0b",
			$time, exp_mis, misaligned);
		report_failure();
	end
	assert (!chk_data || rdata === exp_data) else begin
		$display("MISMATCH at %0t: rdata expected %h, got %h", $time, exp_data, rdata);
		report_failure();
	end
endtask

// one req cycle, response checked at the next falling edge
task automatic access(input logic w, input access_size_e sz, input logic uns,
		input logic [AW-1:0] a, input logic [31:0] d);
	logic        ok;
	logic [31:0] exp_data;
	ok = is_aligned(sz, a);
	exp_data = (!w && ok) ? expected_load(sz, uns, a) : 32'h0;
	req = 1'b1;
	we = w;
	size = sz;
	unsigned_load = uns;
	addr = a;
	wdata = d;
	if (w && ok)
		apply_store(sz, a, d);
	@(negedge clk);
	check_response(!w && ok, !ok, exp_data, !w && ok);
endtask

task automatic go_idle();
	req = 1'b0;
	we = 1'b0;
	@(negedge clk);
	check_response(1'b0, 1'b0, 32'h0, 1'b0); // nothing may trail the last req
endtask

task automatic test_reset();
	repeat (4) begin
		@(negedge clk);
		check_response(1'b0, 1'b0, 32'h0, 1'b1);
	end
	rst_n = 1'b1;
	@(negedge clk);
	check_response(1'b0, 1'b0, 32'h0, 1'b1);
endtask

task automatic test_word_round_trip();
	logic [AW-1:0] addrs [N_ROUND];
	for (int i = 0; i < N_ROUND; i++) begin
		addrs[i] = rand_word_addr();
		access(1'b1, SIZE_WORD, 1'b0, addrs[i], $random(seed));
	end
	for (int i = 0; i < N_ROUND; i++)
		access(1'b0, SIZE_WORD, 1'b0, addrs[i], 32'h0);
	go_idle();
endtask

task automatic test_partial_merge();
	logic [AW-1:0] a;
	for (int i = 0; i < N_MERGE; i++) begin
		a = rand_word_addr();
		access(1'b1, SIZE_WORD, 1'b0, a, $random(seed));
		access(1'b1, SIZE_BYTE, 1'b0, a + AW'(i % 4), $random(seed));
		access(1'b1, SIZE_HALF, 1'b0, a + AW'((i % 2) * 2), $random(seed));
		access(1'b1, SIZE_BYTE, 1'b0, a + AW'((i + 1) % 4), $random(seed));
		access(1'b0, SIZE_WORD, 1'b0, a, 32'h0); // merged word
	end
	go_idle();
endtask

task automatic test_load_extension();
	logic [AW-1:0] a;
	logic [31:0]   pattern [2];
	pattern[0] = 32'hf1e2d3c4;
	pattern[1] = $random(seed) | 32'h80808080; // sign bit set in every lane
	for (int p = 0; p < 2; p++) begin
		a = rand_word_addr();
		access(1'b1, SIZE_WORD, 1'b0, a, pattern[p]);
		for (int off = 0; off < 4; off++)
			for (int u = 0; u < 2; u++)
				access(1'b0, SIZE_BYTE, u[0], a + AW'(off), 32'h0);
		for (int off = 0; off < 4; off += 2)
			for (int u = 0; u < 2; u++)
				access(1'b0, SIZE_HALF, u[0], a + AW'(off), 32'h0);
		access(1'b0, SIZE_WORD, 1'b1, a, 32'h0);
	end
	go_idle();
endtask

task automatic test_misalignment();
	logic [AW-1:0] a;
	a = rand_word_addr();
	access(1'b1, SIZE_WORD, 1'b0, a, $random(seed));
	for (int off = 1; off < 4; off += 2) begin
		access(1'b1, SIZE_HALF, 1'b0, a + AW'(off), $random(seed));
		access(1'b0, SIZE_HALF, 1'b0, a + AW'(off), 32'h0);
	end
	for (int off = 1; off < 4; off++) begin
		access(1'b1, SIZE_WORD, 1'b0, a + AW'(off), $random(seed));
		access(1'b0, SIZE_WORD, 1'b0, a + AW'(off), 32'h0);
	end
	access(1'b0, SIZE_WORD, 1'b0, a, 32'h0); // word must be untouched
	go_idle();
endtask

task automatic test_back_to_back();
	logic [AW-1:0] base;
	base = rand_word_addr();
	for (int i = 0; i < N_B2B; i++)
		access(1'b1, SIZE_WORD, 1'b0, base + AW'(4 * i), $random(seed));
	for (int i = N_B2B - 1; i >= 0; i--)
		access(1'b0, SIZE_WORD, 1'b0, base + AW'(4 * i), 32'h0);
	go_idle();
endtask

initial begin
	seed = 32'hae9c892b;
	clk = 1'b0;
	rst_n = 1'b0;
	req = 1'b0;
	we = 1'b0;
	size = SIZE_BYTE;
	unsigned_load = 1'b0;
	addr = '0;
	wdata = '0;
	test_reset();
	test_word_round_trip();
	test_partial_merge();
	test_load_extension();
	test_misalignment();
	test_back_to_back();
	$display("TEST RESULT: PASS");
	$finish;
end

// watchdog
initial begin
	#(WATCHDOG_TIME);
	$display("watchdog expired before the tests completed");
	report_failure();
end

endmodule

// ==== data_mem.f ====
+incdir+verilog
verilog/data_mem_pkg.sv
verilog/single_port_ram.sv
verilog/single_port_byte_ram.sv
verilog/lsu_align.sv
verilog/data_mem_top.sv
bench/data_mem_asserts.sv
bench/data_mem_tb.sv

// ==== Bender.yml ====
package:
  name: data_mem

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/data_mem_pkg.sv
      - verilog/single_port_ram.sv
      - verilog/single_port_byte_ram.sv
      - verilog/lsu_align.sv
      - verilog/data_mem_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - bench/data_mem_asserts.sv
      - bench/data_mem_tb.sv
